/* Makefile */
TOP := tb_uart_dbg

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f all.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'PASS: all tests'

lint:
	verilator --lint-only -Wall --timing --top-module uart_dbg_top -f all.f

clean:
	rm -rf obj_dir

/* all.f */
src/uart_dbg_pkg.sv
src/bank_port_if.sv
src/uart_rx.sv
src/dbg_cmd_engine.sv
src/mem_bank.sv
src/reply_tx.sv
src/uart_dbg_top.sv
verif/tb_clk_gen.sv
verif/tb_uart_dbg.sv

/* verif/tb_uart_dbg.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_dbg;
  import uart_dbg_pkg::*;

  localparam int unsigned BYTE_TIMEOUT = 1000;
  localparam int unsigned QUIET_CYCLES = 400;
  localparam int unsigned MEM_BYTES    = 1024;

  logic        clk;
  logic        rst;
  logic        uart_rx_line;
  logic        uart_tx_line;
  logic [31:0] lfsr_state;
  byte_t       rx_q [$];
  byte_t       model_mem [MEM_BYTES];
  logic        model_written [MEM_BYTES];
  mem_addr_t   wr_addr_q [$];
  int unsigned wr_len_q [$];
  int unsigned checks;
  int unsigned mismatches;
  int unsigned timeouts;
  int unsigned other_errors;

  tb_clk_gen #(
    .PERIOD_NS    (40),
    .RESET_CYCLES (10)
  ) i_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  uart_dbg_top i_dut (
    .clk       (clk),
    .rst_i     (rst),
    .uart_rx_i (uart_rx_line),
    .uart_tx_o (uart_tx_line)
  );

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Host side of the serial line
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_byte(input byte_t value);
    logic [FRAME_BITS-1:0] frame;
    frame = {1'b1, value, 1'b0};
    @(negedge clk);
    for (int i = 0; i < FRAME_BITS; i++) begin
      uart_rx_line = frame[i];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
  endtask

  // The loader must ignore the random upper field bits
  task automatic send_header(input byte_t cmd, input mem_addr_t addr, input xfer_len_t len);
    logic [8*HDR_FIELD_BYTES-1:0] addr_field;
    logic [8*HDR_FIELD_BYTES-1:0] len_field;
    for (int i = 0; i < HDR_FIELD_BYTES; i++) begin
      addr_field[8*i +: 8] = byte_t'(rand_bits(8));
      len_field[8*i +: 8]  = byte_t'(rand_bits(8));
    end
    addr_field[MEM_ADDR_W-1:0] = addr;
    len_field[XFER_LEN_W-1:0]  = len;
    send_byte(cmd);
    for (int i = 0; i < HDR_FIELD_BYTES; i++) begin
      send_byte(addr_field[8*i +: 8]);
    end
    for (int i = 0; i < HDR_FIELD_BYTES; i++) begin
      send_byte(len_field[8*i +: 8]);
    end
  endtask

  task automatic expect_byte(input byte_t exp, input logic compare, input string what);
    int unsigned waited;
    byte_t       got;
    waited = 0;
    while (rx_q.size() == 0 && waited < BYTE_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (rx_q.size() == 0) begin
      $display("ERROR: no byte on uart_tx_o within %0d cycles while waiting for %s",
               BYTE_TIMEOUT, what);
      timeouts++;
    end else begin
      got = rx_q.pop_front();
      if (compare) begin
        checks++;
        if (got !== exp) begin
          $display("mismatch: uart_tx_o byte (%s) expected 0x%h actual 0x%h", what, exp, got);
          mismatches++;
        end
      end
    end
  endtask

  task automatic check_quiet(input string what);
    repeat (QUIET_CYCLES) @(posedge clk);
    checks++;
    if (rx_q.size() != 0) begin
      $display("ERROR: %0d unexpected bytes on uart_tx_o after %s", rx_q.size(), what);
      other_errors++;
      rx_q.delete();
    end
  endtask

  task automatic check_line_idle(input int unsigned cycles);
    logic seen_low;
    seen_low = 1'b0;
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      if (uart_tx_line !== 1'b1 && !seen_low) begin
        $display("mismatch: uart_tx_o expected 0x1 actual 0x%h", uart_tx_line);
        mismatches++;
        seen_low = 1'b1;
      end
    end
    checks++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Commands against the byte model
  ////////////////////////////////////////////////////////////////////////////

  task automatic do_write(input mem_addr_t addr, input int unsigned len);
    mem_addr_t a;
    byte_t     data;
    send_header(CMD_WRITE, addr, xfer_len_t'(len));
    expect_byte(CODE_ACK, 1'b1, "write ACK");
    a = addr;
    for (int i = 0; i < len; i++) begin
      data = byte_t'(rand_bits(8));
      send_byte(data);
      model_mem[a]     = data;
      model_written[a] = 1'b1;
      // Ten address bits wrap at 1 KiB
      a = a + 1'b1;
    end
    expect_byte(CODE_EOT, 1'b1, "write EOT");
    check_quiet("write");
    if (len != 0) begin
      wr_addr_q.push_back(addr);
      wr_len_q.push_back(len);
    end
  endtask

  task automatic do_read(input mem_addr_t addr, input int unsigned len);
    mem_addr_t a;
    send_header(CMD_READ, addr, xfer_len_t'(len));
    expect_byte(CODE_ACK, 1'b1, "read ACK");
    a = addr;
    for (int i = 0; i < len; i++) begin
      expect_byte(model_mem[a], model_written[a], $sformatf("read data at 0x%h", a));
      a = a + 1'b1;
    end
    expect_byte(CODE_EOT, 1'b1, "read EOT");
    check_quiet("read");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reply monitor that samples mid-bit and queues each byte
  ////////////////////////////////////////////////////////////////////////////

  initial begin : tx_monitor
    logic  line_prev;
    byte_t shift;
    line_prev = 1'b1;
    shift     = '0;
    forever begin
      @(negedge clk);
      if (rst === 1'b0 && line_prev === 1'b1 && uart_tx_line === 1'b0) begin
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        if (uart_tx_line !== 1'b0) begin
          $display("ERROR: start bit on uart_tx_o ended before mid-bit");
          other_errors++;
        end else begin
          for (int i = 0; i < DATA_BITS; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            shift = {uart_tx_line, shift[7:1]};
          end
          repeat (CLKS_PER_BIT) @(negedge clk);
          if (uart_tx_line !== 1'b1) begin
            $display("ERROR: stop bit on uart_tx_o was not high");
            other_errors++;
          end else begin
            rx_q.push_back(shift);
          end
        end
      end
      line_prev = uart_tx_line;
    end
  end

  initial begin : stimulus
    int unsigned idx;
    uart_rx_line = 1'b1;
    lfsr_state   = 32'h4b34_31dd;
    checks       = 0;
    mismatches   = 0;
    timeouts     = 0;
    other_errors = 0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      model_written[i] = 1'b0;
    end
    repeat (12) @(negedge clk);

    // Quiet line after reset and a dropped stray byte
    check_line_idle(500);
    send_byte(8'h55);
    check_line_idle(2000);
    check_quiet("ignored byte 0x55");

    send_byte(CODE_ACK);
    expect_byte(CODE_ACK, 1'b1, "ACK challenge");
    check_quiet("ACK challenge");

    // Fill across the top of memory before the random ranges
    do_write(10'd1020, 8);
    for (int i = 0; i < 20; i++) begin
      do_write(mem_addr_t'(rand_bits(MEM_ADDR_W)), 1 + rand_bits(6) % 40);
    end
    for (int i = 0; i < 10; i++) begin
      idx = rand_bits(5) % wr_addr_q.size();
      do_read(wr_addr_q[idx], wr_len_q[idx]);
    end

    do_read(mem_addr_t'(rand_bits(MEM_ADDR_W)), 0);
    do_write(mem_addr_t'(rand_bits(MEM_ADDR_W)), 0);

    // Bytes 1022 1023 0 1 come from banks 2 3 0 1
    do_read(10'd1022, 4);

    $display("checks %0d, mismatches %0d, timeouts %0d, other errors %0d",
             checks, mismatches, timeouts, other_errors);
    if (mismatches == 0 && timeouts == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS    = 40,
  parameter int unsigned RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

/* src/uart_dbg_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_dbg_top (
  input  logic clk,
  input  logic rst_i,
  input  logic uart_rx_i,
  output logic uart_tx_o
);
  import uart_dbg_pkg::*;

  logic        rx_valid;
  byte_t       rx_byte;
  logic        tx_busy;
  logic        reply_valid;
  reply_code_e reply_code;

  // One access port per byte lane of the interleaved memory
  bank_port_if bank_if [NUM_BANKS] ();

  uart_rx i_uart_rx (
    .clk        (clk),
    .rst_i      (rst_i),
    .rx_i       (uart_rx_i),
    .rx_valid_o (rx_valid),
    .rx_byte_o  (rx_byte)
  );

  dbg_cmd_engine i_engine (
    .clk           (clk),
    .rst_i         (rst_i),
    .rx_valid_i    (rx_valid),
    .rx_byte_i     (rx_byte),
    .tx_busy_i     (tx_busy),
    .reply_valid_o (reply_valid),
    .reply_code_o  (reply_code),
    .banks         (bank_if)
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_banks
    mem_bank i_bank (
      .clk  (clk),
      .port (bank_if[i])
    );
  end

  reply_tx i_reply_tx (
    .clk           (clk),
    .rst_i         (rst_i),
    .reply_valid_i (reply_valid),
    .reply_code_i  (reply_code),
    .tx_busy_o     (tx_busy),
    .tx_o          (uart_tx_o),
    .banks         (bank_if)
  );

endmodule

`default_nettype wire

/* src/reply_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module reply_tx (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      reply_valid_i,
  input  uart_dbg_pkg::reply_code_e reply_code_i,
  output logic                      tx_busy_o,
  output logic                      tx_o,
  bank_port_if.reply                banks [uart_dbg_pkg::NUM_BANKS]
);
  import uart_dbg_pkg::*;

  logic [NUM_BANKS-1:0]  rd_strobe;
  byte_t                 bank_rdata [NUM_BANKS];
  bank_sel_t             strobe_sel;
  bank_sel_t             sel_q;
  logic                  pend_q;
  logic                  busy_q;
  logic [FRAME_BITS-1:0] frame_q;
  baud_cnt_t             baud_q;
  bit_cnt_t              bit_q;
  byte_t                 code_byte;

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_taps
    assign rd_strobe[i]  = banks[i].en && !banks[i].we;
    assign bank_rdata[i] = banks[i].rdata;
  end

  // At most one bank reads per cycle
  always_comb begin
    strobe_sel = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (rd_strobe[i]) begin
        strobe_sel = bank_sel_t'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (|rd_strobe) begin
      sel_q <= strobe_sel;
    end
  end

  assign code_byte = (reply_code_i == REPLY_ACK) ? CODE_ACK : CODE_EOT;

  ////////////////////////////////////////////////////////////////////////////
  // Frame shifter, stop bit shifts in behind the data
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      busy_q  <= 1'b0;
      pend_q  <= 1'b0;
      frame_q <= '1;
      baud_q  <= '0;
      bit_q   <= '0;
    end else if (reply_valid_i) begin
      busy_q  <= 1'b1;
      frame_q <= {1'b1, code_byte, 1'b0};
      baud_q  <= '0;
      bit_q   <= '0;
    end else if (|rd_strobe) begin
      busy_q <= 1'b1;
      pend_q <= 1'b1;
    end else if (pend_q) begin
      // Bank data is valid one cycle after the strobe
      pend_q  <= 1'b0;
      frame_q <= {1'b1, bank_rdata[sel_q], 1'b0};
      baud_q  <= '0;
      bit_q   <= '0;
    end else if (busy_q) begin
      if (baud_q == BAUD_LAST) begin
        baud_q  <= '0;
        frame_q <= {1'b1, frame_q[FRAME_BITS-1:1]};
        if (bit_q == bit_cnt_t'(FRAME_BITS - 1)) begin
          busy_q <= 1'b0;
        end else begin
          bit_q <= bit_q + 1'b1;
        end
      end else begin
        baud_q <= baud_q + 1'b1;
      end
    end
  end

  assign tx_o      = frame_q[0];
  assign tx_busy_o = busy_q;

endmodule

`default_nettype wire

/* src/mem_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_bank (
  input logic        clk,
  bank_port_if.bank  port
);
  import uart_dbg_pkg::*;

  byte_t mem_q [BANK_DEPTH];

  // Single port, write or read per access
  always_ff @(posedge clk) begin
    if (port.en) begin
      if (port.we) begin
        mem_q[port.addr] <= port.wdata;
      end else begin
        port.rdata <= mem_q[port.addr];
      end
    end
  end

endmodule

`default_nettype wire

/* src/dbg_cmd_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module dbg_cmd_engine (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      rx_valid_i,
  input  uart_dbg_pkg::byte_t       rx_byte_i,
  input  logic                      tx_busy_i,
  output logic                      reply_valid_o,
  output uart_dbg_pkg::reply_code_e reply_code_o,
  bank_port_if.engine               banks [uart_dbg_pkg::NUM_BANKS]
);
  import uart_dbg_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    ADDR,
    LEN,
    SEND_ACK,
    WRITE_DATA,
    READ_DATA,
    SEND_EOT
  } state_e;

  state_e     state_q;
  hdr_cnt_t   hdr_cnt_q;
  logic       is_write_q;
  logic       ack_only_q;
  mem_addr_t  addr_q;
  xfer_len_t  len_q;
  logic       len_last;
  logic       acc_en;
  logic       acc_we;
  bank_sel_t  acc_sel;
  bank_addr_t acc_addr;

  ////////////////////////////////////////////////////////////////////////////
  // Command FSM
  ////////////////////////////////////////////////////////////////////////////

  assign len_last = (len_q == xfer_len_t'(1));

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q    <= IDLE;
      hdr_cnt_q  <= '0;
      is_write_q <= 1'b0;
      ack_only_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          hdr_cnt_q  <= '0;
          ack_only_q <= 1'b0;
          if (rx_valid_i) begin
            if (rx_byte_i == CMD_READ) begin
              is_write_q <= 1'b0;
              state_q    <= ADDR;
            end else if (rx_byte_i == CMD_WRITE) begin
              is_write_q <= 1'b1;
              state_q    <= ADDR;
            end else if (rx_byte_i == CODE_ACK) begin
              // Host checks that the loader is alive
              ack_only_q <= 1'b1;
              state_q    <= SEND_ACK;
            end
          end
        end
        ADDR, LEN: begin
          if (rx_valid_i) begin
            hdr_cnt_q <= hdr_cnt_q + 1'b1;
            if (hdr_cnt_q == HDR_LAST) begin
              state_q <= (state_q == ADDR) ? LEN : SEND_ACK;
            end
          end
        end
        SEND_ACK: begin
          if (!tx_busy_i) begin
            if (ack_only_q) begin
              state_q <= IDLE;
            end else if (len_q == '0) begin
              state_q <= SEND_EOT;
            end else begin
              state_q <= is_write_q ? WRITE_DATA : READ_DATA;
            end
          end
        end
        WRITE_DATA, READ_DATA: begin
          if (acc_en && len_last) begin
            state_q <= SEND_EOT;
          end
        end
        default: begin
          if (!tx_busy_i) begin
            state_q <= IDLE;
          end
        end
      endcase
    end
  end

  // Only the low header bytes matter, upper bytes are dropped
  always_ff @(posedge clk) begin
    if (rx_valid_i && state_q == ADDR) begin
      if (hdr_cnt_q == '0) begin
        addr_q[7:0] <= rx_byte_i;
      end else if (hdr_cnt_q == hdr_cnt_t'(1)) begin
        addr_q[MEM_ADDR_W-1:8] <= rx_byte_i[MEM_ADDR_W-9:0];
      end
    end else if (rx_valid_i && state_q == LEN) begin
      if (hdr_cnt_q == '0) begin
        len_q[7:0] <= rx_byte_i;
      end else if (hdr_cnt_q == hdr_cnt_t'(1)) begin
        len_q[15:8] <= rx_byte_i;
      end
    end else if (acc_en) begin
      // Address wraps at the top of memory
      addr_q <= addr_q + 1'b1;
      len_q  <= len_q - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bank accesses and reply requests
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    acc_en = 1'b0;
    if (state_q == WRITE_DATA) begin
      acc_en = rx_valid_i;
    end else if (state_q == READ_DATA) begin
      acc_en = !tx_busy_i;
    end
  end

  assign acc_we   = (state_q == WRITE_DATA);
  assign acc_sel  = addr_q[BANK_SEL_W-1:0];
  assign acc_addr = addr_q[MEM_ADDR_W-1:BANK_SEL_W];

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_ports
    assign banks[i].en    = acc_en && (acc_sel == bank_sel_t'(i));
    assign banks[i].we    = acc_we;
    assign banks[i].addr  = acc_addr;
    assign banks[i].wdata = rx_byte_i;
  end

  assign reply_valid_o = ((state_q == SEND_ACK) || (state_q == SEND_EOT)) && !tx_busy_i;
  assign reply_code_o  = (state_q == SEND_EOT) ? REPLY_EOT : REPLY_ACK;

endmodule

`default_nettype wire

/* src/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                rx_i,
  output logic                rx_valid_o,
  output uart_dbg_pkg::byte_t rx_byte_o
);
  import uart_dbg_pkg::*;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e state_q;
  logic      rx_meta_q;
  logic      rx_sync_q;
  baud_cnt_t baud_q;
  bit_cnt_t  bit_q;
  byte_t     shift_q;

  // Two-flop synchronizer, line idles high
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q    <= RX_IDLE;
      baud_q     <= '0;
      bit_q      <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          baud_q <= '0;
          if (!rx_sync_q) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (baud_q == BAUD_MID) begin
            baud_q <= '0;
            bit_q  <= '0;
            // Glitch on the line, not a real start bit
            state_q <= rx_sync_q ? RX_IDLE : RX_DATA;
          end else begin
            baud_q <= baud_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (baud_q == BAUD_LAST) begin
            baud_q <= '0;
            if (bit_q == bit_cnt_t'(DATA_BITS - 1)) begin
              state_q <= RX_STOP;
            end else begin
              bit_q <= bit_q + 1'b1;
            end
          end else begin
            baud_q <= baud_q + 1'b1;
          end
        end
        default: begin
          // Mid stop bit, drop the byte on a framing error
          if (baud_q == BAUD_LAST) begin
            rx_valid_o <= rx_sync_q;
            state_q    <= RX_IDLE;
          end else begin
            baud_q <= baud_q + 1'b1;
          end
        end
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && baud_q == BAUD_LAST) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign rx_byte_o = shift_q;

endmodule

`default_nettype wire

/* src/bank_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface bank_port_if;
  import uart_dbg_pkg::*;

  logic       en;
  logic       we;
  bank_addr_t addr;
  byte_t      wdata;
  byte_t      rdata;

  // Access side, one port per bank
  modport engine (output en, output we, output addr, output wdata);

  modport bank (input en, input we, input addr, input wdata, output rdata);

  // Watches read strobes and picks up the read data
  modport reply (input en, input we, input rdata);

endinterface

`default_nettype wire

/* src/uart_dbg_pkg.sv */
`default_nettype none

package uart_dbg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Line timing and memory geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned CLKS_PER_BIT    = 16;
  localparam int unsigned DATA_BITS       = 8;
  // Start, data and stop bits
  localparam int unsigned FRAME_BITS      = DATA_BITS + 2;

  localparam int unsigned NUM_BANKS       = 4;
  localparam int unsigned MEM_ADDR_W      = 10;
  localparam int unsigned BANK_SEL_W      = $clog2(NUM_BANKS);
  localparam int unsigned BANK_ADDR_W     = MEM_ADDR_W - BANK_SEL_W;
  localparam int unsigned BANK_DEPTH      = 2 ** BANK_ADDR_W;
  localparam int unsigned XFER_LEN_W      = 16;
  localparam int unsigned HDR_FIELD_BYTES = 8;

  typedef logic [7:0]             byte_t;
  typedef logic [MEM_ADDR_W-1:0]  mem_addr_t;
  typedef logic [BANK_SEL_W-1:0]  bank_sel_t;
  typedef logic [BANK_ADDR_W-1:0] bank_addr_t;
  typedef logic [XFER_LEN_W-1:0]  xfer_len_t;

  typedef logic [$clog2(CLKS_PER_BIT)-1:0]    baud_cnt_t;
  typedef logic [$clog2(FRAME_BITS)-1:0]      bit_cnt_t;
  typedef logic [$clog2(HDR_FIELD_BYTES)-1:0] hdr_cnt_t;

  localparam baud_cnt_t BAUD_MID  = baud_cnt_t'(CLKS_PER_BIT / 2 - 1);
  localparam baud_cnt_t BAUD_LAST = baud_cnt_t'(CLKS_PER_BIT - 1);
  localparam hdr_cnt_t  HDR_LAST  = hdr_cnt_t'(HDR_FIELD_BYTES - 1);

  ////////////////////////////////////////////////////////////////////////////
  // Debug protocol bytes
  ////////////////////////////////////////////////////////////////////////////

  localparam byte_t CMD_READ  = 8'h11;
  localparam byte_t CMD_WRITE = 8'h12;
  localparam byte_t CODE_ACK  = 8'h06;
  localparam byte_t CODE_EOT  = 8'h04;

  // Reply requests from the engine to the transmitter
  typedef enum logic {
    REPLY_ACK,
    REPLY_EOT
  } reply_code_e;

endpackage

`default_nettype wire
